// File: compile.f
+incdir+hdl
hdl/sysbus_pkg.sv
hdl/bus_controller.sv
hdl/slave_ram.sv
hdl/read_return.sv
hdl/sysbus_top.sv
tests/sysbus_chk.sv
tests/sysbus_tb.sv

// File: hdl/bus_controller.sv
`default_nettype none

`include "sysbus_params.svh"

module bus_controller (
  input  wire                         clock,
  input  wire                         reset_n,
  input  wire sysbus_pkg::addr_t      cpu_address,
  input  wire sysbus_pkg::addr_t      vga_address,
  input  wire                         cpu_read,
  input  wire                         vga_read,
  input  wire                         cpu_write,
  input  wire sysbus_pkg::strobe_t    cpu_be,
  input  wire sysbus_pkg::data_t      cpu_writedata,
  input  wire                         map,
  output sysbus_pkg::addr_t           address,
  output logic                        read,
  output logic                        write,
  output sysbus_pkg::strobe_t         be,
  output sysbus_pkg::data_t           writedata,
  output sysbus_pkg::slave_sel_t      chipselect,
  output logic                        start,
  output logic                        cpu_wait,
  output logic                        vga_wait,
  output logic                        grant_cpu,
  output logic                        grant_vga,
  output logic                        done
);
  import sysbus_pkg::*;

  // Low address bit of the region compare, 256-byte regions
  localparam int region_lsb = $clog2(`SYSBUS_RAM_WORDS * 4);
  localparam logic [3:0] wait_load = 4'(`SYSBUS_WAIT_STATES);

  bus_state_t state;
  bus_state_t state_next;
  logic [3:0] delay;
  logic [3:0] delay_next;
  logic       grant_cpu_next;
  logic       grant_vga_next;
  logic       cpu_req;
  logic       vga_req;
  logic       owner_req;
  addr_t      region_base [`SYSBUS_SLAVES];
  slave_sel_t cs_decode;

  assign cpu_req   = cpu_read | cpu_write;
  assign vga_req   = vga_read;
  assign owner_req = (grant_cpu & cpu_req) | (grant_vga & vga_req); // Owner still asking

  // Master multiplexer, VGA only reads whole words
  always_comb begin
    address   = '0;
    read      = 1'b0;
    write     = 1'b0;
    be        = '0;
    writedata = '0;
    if (grant_cpu) begin
      address   = cpu_address;
      read      = cpu_read;
      write     = cpu_write;
      be        = cpu_be;
      writedata = cpu_writedata;
    end else if (grant_vga) begin
      address = vga_address;
      read    = vga_read;
      be      = '1;
    end
  end

  // Map 1 swaps the internal RAM to address zero
  always_comb begin
    region_base[0] = map ? `SYSBUS_BASE_IRAM : `SYSBUS_BASE_SRAM;
    region_base[1] = `SYSBUS_BASE_IO;
    region_base[2] = `SYSBUS_BASE_ROM;
    region_base[3] = map ? `SYSBUS_BASE_SRAM : `SYSBUS_BASE_IRAM;
  end

  always_comb begin
    for (int i = 0; i < `SYSBUS_SLAVES; i++) begin
      cs_decode[i] = (address[31:region_lsb] == region_base[i][31:region_lsb]);
    end
  end

  assign chipselect = (state == bus_idle) ? '0 : cs_decode;
  assign start      = (state == bus_start);
  assign done       = (state == bus_post);
  assign cpu_wait   = grant_cpu ? (state != bus_post) : 1'b1;
  assign vga_wait   = grant_vga ? (state != bus_post) : 1'b1;

  always_comb begin
    state_next     = state;
    delay_next     = delay;
    grant_cpu_next = grant_cpu;
    grant_vga_next = grant_vga;
    case (state)
      bus_idle: begin
        if (cpu_req) begin // CPU has priority
          grant_cpu_next = 1'b1;
          state_next     = bus_start;
        end else if (vga_req) begin
          grant_vga_next = 1'b1;
          state_next     = bus_start;
        end
      end
      bus_start: begin
        delay_next = wait_load;
        state_next = owner_req ? bus_pre : bus_idle;
      end
      bus_pre: begin
        if (!owner_req) begin
          state_next = bus_idle; // Aborted
        end else if (delay == 4'd0) begin
          state_next = bus_post;
        end else begin
          delay_next = delay - 4'd1;
        end
      end
      bus_post: begin
        // Request drop ends the transfer
        if (!owner_req) begin
          state_next = bus_idle;
        end
      end
      default: begin
        state_next = bus_idle;
      end
    endcase
    if (state_next == bus_idle) begin
      grant_cpu_next = 1'b0;
      grant_vga_next = 1'b0;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state     <= bus_idle;
      delay     <= 4'd0;
      grant_cpu <= 1'b0;
      grant_vga <= 1'b0;
    end else begin
      state     <= state_next;
      delay     <= delay_next;
      grant_cpu <= grant_cpu_next;
      grant_vga <= grant_vga_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/read_return.sv
`default_nettype none

`include "sysbus_params.svh"

module read_return (
  input  wire                         clock,
  input  wire                         reset_n,
  input  wire sysbus_pkg::data_t      slave_rdata [`SYSBUS_SLAVES],
  input  wire sysbus_pkg::slave_sel_t chipselect,
  input  wire                         read,
  input  wire                         grant_cpu,
  input  wire                         grant_vga,
  input  wire                         done,
  output sysbus_pkg::data_t           cpu_readdata,
  output sysbus_pkg::data_t           vga_readdata
);
  import sysbus_pkg::*;

  data_t selected;
  logic  load_cpu;
  logic  load_vga;

  // One-hot select, zero when no slave answers
  always_comb begin
    selected = '0;
    for (int i = 0; i < `SYSBUS_SLAVES; i++) begin
      if (chipselect[i]) begin
        selected |= slave_rdata[i];
      end
    end
  end

  assign load_cpu = done & read & grant_cpu;
  assign load_vga = done & read & grant_vga;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      cpu_readdata <= '0;
      vga_readdata <= '0;
    end else begin
      if (load_cpu) begin
        cpu_readdata <= selected;
      end
      if (load_vga) begin
        vga_readdata <= selected;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/slave_ram.sv
`default_nettype none

`include "sysbus_params.svh"

module slave_ram (
  input  wire                          clock,
  input  wire                          reset_n,
  input  wire                          select,
  input  wire                          read,
  input  wire                          write,
  input  wire sysbus_pkg::strobe_t     be,
  input  wire sysbus_pkg::word_index_t index,
  input  wire sysbus_pkg::data_t       writedata,
  output sysbus_pkg::data_t            rdata
);
  import sysbus_pkg::*;

  localparam int lanes = $bits(strobe_t);

  data_t mem [`SYSBUS_RAM_WORDS];
  logic  write_en;
  logic  read_en;

  assign write_en = select & write;
  assign read_en  = select & read;

  // Byte lanes written independently
  always_ff @(posedge clock) begin
    if (write_en) begin
      for (int b = 0; b < lanes; b++) begin
        if (be[b]) begin
          mem[index][8*b +: 8] <= writedata[8*b +: 8];
        end
      end
    end
  end

  // Registered read port, held between reads
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rdata <= '0;
    end else if (read_en) begin
      rdata <= mem[index];
    end
  end

endmodule

`default_nettype wire

// File: hdl/sysbus_params.svh
`ifndef SYSBUS_PARAMS_SVH
`define SYSBUS_PARAMS_SVH

// Slaves on the bus, one chip select each
`define SYSBUS_SLAVES 4

// Count loaded in bus_pre, 0 to 15
`define SYSBUS_WAIT_STATES 2

`define SYSBUS_RAM_WORDS 64 // Words per RAM slave

// Region bases, each region spans 256 bytes
`define SYSBUS_BASE_SRAM 32'h0000_0000
`define SYSBUS_BASE_IO   32'h0080_0000
`define SYSBUS_BASE_ROM  32'hFFFF_0000
`define SYSBUS_BASE_IRAM 32'hFFFF_8000

`endif

// File: hdl/sysbus_pkg.sv
`default_nettype none

`include "sysbus_params.svh"

package sysbus_pkg;

  typedef logic [31:0] addr_t;   // Byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strobe_t; // One enable per byte lane

  // One-hot chip select
  typedef logic [`SYSBUS_SLAVES-1:0] slave_sel_t;

  typedef logic [$clog2(`SYSBUS_RAM_WORDS)-1:0] word_index_t;

  typedef enum logic [1:0] {
    bus_idle,
    bus_start,
    bus_pre,  // Wait states counting down
    bus_post  // Granted master released
  } bus_state_t;

endpackage

`default_nettype wire

// File: hdl/sysbus_top.sv
`default_nettype none

`include "sysbus_params.svh"

module sysbus_top (
  input  wire                      clock,
  input  wire                      reset_n,
  input  wire sysbus_pkg::addr_t   cpu_address,
  input  wire                      cpu_read,
  input  wire                      cpu_write,
  input  wire sysbus_pkg::strobe_t cpu_be,
  input  wire sysbus_pkg::data_t   cpu_writedata,
  output wire                      cpu_wait,
  output sysbus_pkg::data_t        cpu_readdata,
  input  wire sysbus_pkg::addr_t   vga_address,
  input  wire                      vga_read,
  output wire                      vga_wait,
  output sysbus_pkg::data_t        vga_readdata,
  input  wire                      map
);
  import sysbus_pkg::*;

  addr_t      address;
  logic       read;
  logic       write;
  strobe_t    be;
  data_t      writedata;
  slave_sel_t chipselect;
  logic       start;
  logic       grant_cpu;
  logic       grant_vga;
  logic       done;
  data_t      slave_rdata [`SYSBUS_SLAVES];

  bus_controller u_bus_controller (
    .clock         (clock),
    .reset_n       (reset_n),
    .cpu_address   (cpu_address),
    .vga_address   (vga_address),
    .cpu_read      (cpu_read),
    .vga_read      (vga_read),
    .cpu_write     (cpu_write),
    .cpu_be        (cpu_be),
    .cpu_writedata (cpu_writedata),
    .map           (map),
    .address       (address),
    .read          (read),
    .write         (write),
    .be            (be),
    .writedata     (writedata),
    .chipselect    (chipselect),
    .start         (start),
    .cpu_wait      (cpu_wait),
    .vga_wait      (vga_wait),
    .grant_cpu     (grant_cpu),
    .grant_vga     (grant_vga),
    .done          (done)
  );

  for (genvar i = 0; i < `SYSBUS_SLAVES; i++) begin : g_slave
    slave_ram u_slave_ram (
      .clock     (clock),
      .reset_n   (reset_n),
      .select    (chipselect[i]),
      .read      (read),
      .write     (write),
      .be        (be),
      .index     (address[7:2]), // Word within the 256-byte region
      .writedata (writedata),
      .rdata     (slave_rdata[i])
    );
  end

  read_return u_read_return (
    .clock        (clock),
    .reset_n      (reset_n),
    .slave_rdata  (slave_rdata),
    .chipselect   (chipselect),
    .read         (read),
    .grant_cpu    (grant_cpu),
    .grant_vga    (grant_vga),
    .done         (done),
    .cpu_readdata (cpu_readdata),
    .vga_readdata (vga_readdata)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module sysbus_tb -o sysbus_sim \
  && ./obj_dir/sysbus_sim | tee /dev/stderr | grep -F "All tests passed!" > /dev/null \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// File: tests/sysbus_chk.sv
`default_nettype none

module sysbus_chk (
  input wire                         clock,
  input wire                         reset_n,
  input wire sysbus_pkg::slave_sel_t chipselect,
  input wire                         cpu_wait,
  input wire                         vga_wait,
  input wire                         start,
  input wire                         write,
  input wire                         grant_vga
);

  chipselect_onehot: assert property (
    @(posedge clock) disable iff (!reset_n) $onehot0(chipselect)
  ) else $error("chipselect drives more than one slave");

  // Only the granted master can be released
  single_release: assert property (
    @(posedge clock) disable iff (!reset_n) !(!cpu_wait && !vga_wait)
  ) else $error("cpu_wait and vga_wait are low together");

  start_one_cycle: assert property (
    @(posedge clock) disable iff (!reset_n) start |=> !start
  ) else $error("start stays high for more than one cycle");

  vga_read_only: assert property (
    @(posedge clock) disable iff (!reset_n) !(write && grant_vga)
  ) else $error("write is high while VGA owns the bus");

endmodule

`default_nettype wire

// File: tests/sysbus_tb.sv
`default_nettype none

`include "sysbus_params.svh"

module sysbus_tb;
  import sysbus_pkg::*;

  localparam int timeout_cycles = 200; // VGA may sit behind a CPU transfer
  localparam int words = `SYSBUS_RAM_WORDS;

  logic    clock;
  logic    reset_n;
  addr_t   cpu_address;
  logic    cpu_read;
  logic    cpu_write;
  strobe_t cpu_be;
  data_t   cpu_writedata;
  logic    cpu_wait;
  data_t   cpu_readdata;
  addr_t   vga_address;
  logic    vga_read;
  logic    vga_wait;
  data_t   vga_readdata;
  logic    map;
  logic    cpu_finished;
  data_t   model_mem [int]; // Slave * words + index
  addr_t   written [$];

  sysbus_top u_sysbus_top (.*);

  bind sysbus_top sysbus_chk u_sysbus_chk (
    .clock      (clock),
    .reset_n    (reset_n),
    .chipselect (chipselect),
    .cpu_wait   (cpu_wait),
    .vga_wait   (vga_wait),
    .start      (start),
    .write      (write),
    .grant_vga  (grant_vga)
  );

  always #2 clock = ~clock;

  // Slave number or -1 when unmapped
  function automatic int slave_of(input addr_t addr, input logic map_sel);
    case (addr[31:8])
      24'h00_0000: return map_sel ? 3 : 0;
      24'h00_8000: return 1;
      24'hFF_FF00: return 2;
      24'hFF_FF80: return map_sel ? 0 : 3;
      default:     return -1;
    endcase
  endfunction

  function automatic addr_t base_of(input int slave, input logic map_sel);
    case (slave)
      0:       return map_sel ? 32'hFFFF_8000 : 32'h0000_0000;
      1:       return 32'h0080_0000;
      2:       return 32'hFFFF_0000;
      default: return map_sel ? 32'h0000_0000 : 32'hFFFF_8000;
    endcase
  endfunction

  function automatic int key_of(input addr_t addr, input logic map_sel);
    return slave_of(addr, map_sel) * words + int'(addr[7:2]);
  endfunction

  function automatic data_t model_read(input addr_t addr, input logic map_sel);
    if (slave_of(addr, map_sel) < 0) begin
      return '0; // Nobody answers
    end
    return model_mem[key_of(addr, map_sel)];
  endfunction

  function automatic void model_write(input addr_t addr, input strobe_t strb,
                                      input data_t data, input logic map_sel);
    data_t word;
    if (slave_of(addr, map_sel) >= 0) begin
      word = model_mem[key_of(addr, map_sel)];
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          word[8*b +: 8] = data[8*b +: 8];
        end
      end
      model_mem[key_of(addr, map_sel)] = word;
    end
  endfunction

  function automatic addr_t random_mapped_addr(input logic map_sel);
    int slave;
    int index;
    slave = int'($urandom_range(3, 0));
    index = int'($urandom_range(words - 1, 0));
    return base_of(slave, map_sel) + addr_t'(index * 4);
  endfunction

  function automatic addr_t random_unmapped_addr(input logic map_sel);
    addr_t addr;
    do begin
      addr = $urandom;
    end while (slave_of(addr, map_sel) >= 0);
    return addr;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("ERROR: %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  task automatic cpu_access(input addr_t addr, input logic wr, input strobe_t strb,
                            input data_t wdata, output data_t rdata);
    int cycles;
    cpu_address   = addr;
    cpu_read      = ~wr;
    cpu_write     = wr;
    cpu_be        = strb;
    cpu_writedata = wdata;
    cycles        = 0;
    do begin
      @(posedge clock);
      #1;
      cycles++;
      if (cycles > timeout_cycles) begin
        fail_run("Timeout: cpu_wait never went low");
      end
    end while (cpu_wait);
    check_value("vga_wait_during_cpu", 32'd1, 32'(vga_wait));
    @(posedge clock); // End of done cycle latches readdata
    #1;
    cpu_read  = 1'b0;
    cpu_write = 1'b0;
    rdata     = cpu_readdata;
    @(posedge clock); // Controller sees the drop
    #1;
  endtask

  task automatic vga_access(input addr_t addr, output data_t rdata);
    int cycles;
    vga_address = addr;
    vga_read    = 1'b1;
    cycles      = 0;
    do begin
      @(posedge clock);
      #1;
      cycles++;
      if (cycles > timeout_cycles) begin
        fail_run("Timeout: vga_wait never went low");
      end
    end while (vga_wait);
    check_value("cpu_wait_during_vga", 32'd1, 32'(cpu_wait));
    @(posedge clock);
    #1;
    vga_read = 1'b0;
    rdata    = vga_readdata;
    @(posedge clock);
    #1;
  endtask

  task automatic cpu_store(input addr_t addr, input strobe_t strb, input data_t data);
    data_t ignored;
    cpu_access(addr, 1'b1, strb, data, ignored);
    model_write(addr, strb, data, map);
  endtask

  task automatic cpu_load_check(input string name, input addr_t addr);
    data_t rdata;
    cpu_access(addr, 1'b0, 4'hF, '0, rdata);
    check_value(name, model_read(addr, map), rdata);
  endtask

  task automatic verify_all(input string name);
    for (int s = 0; s < `SYSBUS_SLAVES; s++) begin
      for (int i = 0; i < words; i++) begin
        cpu_load_check(name, base_of(s, map) + addr_t'(i * 4));
      end
    end
  endtask

  initial begin
    data_t   rdata;
    data_t   wdata;
    data_t   vga_data;
    addr_t   addr;
    addr_t   vga_addr;
    strobe_t strb;
    void'($urandom(95));
    clock         = 1'b0;
    reset_n       = 1'b0;
    cpu_address   = '0;
    cpu_read      = 1'b0;
    cpu_write     = 1'b0;
    cpu_be        = '0;
    cpu_writedata = '0;
    vga_address   = '0;
    vga_read      = 1'b0;
    map           = 1'b0;
    cpu_finished  = 1'b0;
    repeat (16) @(posedge clock);
    #1;
    reset_n = 1'b1;

    check_value("reset_cpu_wait", 32'd1, 32'(cpu_wait));
    check_value("reset_vga_wait", 32'd1, 32'(vga_wait));
    check_value("reset_cpu_readdata", 32'h0, cpu_readdata);
    check_value("reset_vga_readdata", 32'h0, vga_readdata);

    for (int s = 0; s < `SYSBUS_SLAVES; s++) begin
      for (int i = 0; i < words; i++) begin
        addr = base_of(s, map) + addr_t'(i * 4);
        cpu_store(addr, 4'hF, {addr[15:0], addr[31:16]} ^ 32'h5AC3_3CA5);
      end
    end

    for (int n = 0; n < 200; n++) begin
      addr = random_mapped_addr(map);
      cpu_store(addr, strobe_t'($urandom_range(15, 0)), $urandom);
      written.push_back(addr);
    end
    for (int n = 0; n < 200; n++) begin
      cpu_load_check("cpu_random_read", random_mapped_addr(map));
    end

    for (int n = 0; n < 50; n++) begin
      addr = written[$urandom_range(written.size() - 1, 0)];
      vga_access(addr, vga_data);
      check_value("vga_read_written", model_read(addr, map), vga_data);
    end

    for (int n = 0; n < 20; n++) begin
      addr = random_unmapped_addr(map);
      cpu_access(addr, 1'b0, 4'hF, '0, rdata);
      check_value("unmapped_read_zero", 32'h0, rdata);
      cpu_store(addr, 4'hF, $urandom); // Model ignores it too
    end
    verify_all("after_unmapped_writes");

    map = 1'b1;
    cpu_access(32'h0000_0000, 1'b0, 4'hF, '0, rdata);
    check_value("iram_at_zero", model_mem[key_of(32'hFFFF_8000, 1'b0)], rdata);
    cpu_store(32'h0000_0004, 4'h3, $urandom);
    verify_all("map1_sweep");
    map = 1'b0;
    verify_all("map0_sweep");

    // CPU wins same-cycle requests
    for (int n = 0; n < 20; n++) begin
      addr         = random_mapped_addr(map);
      wdata        = $urandom;
      strb         = strobe_t'($urandom_range(15, 0));
      vga_addr     = ($urandom_range(1, 0) == 1) ? addr : random_mapped_addr(map);
      cpu_finished = 1'b0;
      fork
        begin
          cpu_access(addr, 1'b1, strb, wdata, rdata);
          cpu_finished = 1'b1;
        end
        begin
          vga_access(vga_addr, vga_data);
          check_value("vga_after_cpu", 32'd1, 32'(cpu_finished));
        end
      join
      model_write(addr, strb, wdata, map);
      check_value("vga_shared_read", model_read(vga_addr, map), vga_data);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
